// ==== Makefile ====
# Verilator build and run of the md_unit execute slice testbench

VERILATOR ?= verilator
TOP       ?= md_unit_tb
FILELIST  ?= md_unit_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the simulator
run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/md_unit_chk.sv ====
`timescale 1ns/1ps

module md_unit_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic busy_i,
  input logic result_valid_i
);

  // count of failed assertions
  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // result strobe
  ////////////////////////////////////////

  // first edge out of reset
  valid_low_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !result_valid_i
  ) else begin
    fail_count++;
    $error("result_valid_o high on the first edge after reset");
  end

  valid_single_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    result_valid_i |=> !result_valid_i
  ) else begin
    fail_count++;
    $error("result_valid_o high for two cycles in a row");
  end

  // a result only ends a busy period
  valid_needs_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(result_valid_i) |-> $past(busy_i)
  ) else begin
    fail_count++;
    $error("result_valid_o rose without busy_o in the previous cycle");
  end

  ////////////////////////////////////////
  // request acceptance
  ////////////////////////////////////////

  busy_after_accept: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !busy_i) |=> busy_i
  ) else begin
    fail_count++;
    $error("busy_o did not rise after an accepted request");
  end

endmodule

bind md_unit_top md_unit_chk u_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_valid_i    (req_valid_i),
  .busy_i         (busy_o),
  .result_valid_i (result_valid_o)
);

// ==== dv/md_unit_tb.sv ====
`timescale 1ns/1ps

module md_unit_tb;

  import md_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          DRIVE_DLY    = 1;
  localparam int          RESET_CYCLES = 4;
  localparam int          NUM_FUNCS    = 10;
  localparam int          NUM_PER_FUNC = 24;
  localparam int          NUM_DIRECTED = 10;
  localparam int          NUM_OPS      = NUM_FUNCS * NUM_PER_FUNC + NUM_DIRECTED;
  // slowest divide is under 40 cycles
  localparam int          WATCHDOG_CYC = NUM_OPS * 40 + 200;
  localparam logic [15:0] LFSR_SEED    = 16'd16608;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  md_req_t  req;
  logic     busy;
  logic     result_valid;
  md_word_t result;

  logic [15:0] lfsr;
  md_req_t     pending[$];
  int          n_issued;
  int          n_results;

  md_unit_top dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .busy_o         (busy),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input md_word_t got, input md_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  // x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
  endfunction

  function automatic md_word_t rand_word(input int n);
    md_word_t val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // a quarter corner values, some small magnitudes for the divider
  function automatic md_word_t rand_operand();
    logic [3:0] pick;
    pick = 4'(rand_word(4));
    case (pick)
      4'd0:    return '0;
      4'd1:    return 32'd1;
      4'd2:    return '1;
      4'd3:    return 32'h8000_0000;
      4'd4:    return rand_word(6);
      4'd5:    return ~rand_word(6);
      default: return rand_word(32);
    endcase
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic md_word_t ref_result(input md_req_t r);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    md_word_t    mag_a;
    md_word_t    mag_b;
    md_word_t    quot;
    md_word_t    rem;
    logic        signed_div;
    logic        neg_a;
    logic        neg_b;
    logic        overflow;
    // 64-bit product of the extended operands
    ext_a = (r.func inside {FN_MULH, FN_MULHSU}) ? {{32{r.op_a[31]}}, r.op_a} : {32'b0, r.op_a};
    ext_b = (r.func == FN_MULH) ? {{32{r.op_b[31]}}, r.op_b} : {32'b0, r.op_b};
    prod  = ext_a * ext_b;
    // divide on magnitudes, then fix the signs
    signed_div = r.func inside {FN_DIV, FN_REM};
    neg_a      = signed_div && r.op_a[31];
    neg_b      = signed_div && r.op_b[31];
    overflow   = signed_div && (r.op_a == 32'h8000_0000) && (r.op_b == '1);
    mag_a      = neg_a ? -r.op_a : r.op_a;
    mag_b      = neg_b ? -r.op_b : r.op_b;
    quot       = '0;
    rem        = '0;
    if (mag_b != '0) begin
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
    end
    case (r.func)
      FN_ADD:                       return r.op_a + r.op_b;
      FN_SUB:                       return r.op_a - r.op_b;
      FN_MUL:                       return prod[31:0];
      FN_MULH, FN_MULHSU, FN_MULHU: return prod[63:32];
      FN_DIV, FN_DIVU: begin
        if (r.op_b == '0) return '1;
        if (overflow) return 32'h8000_0000;
        return (neg_a ^ neg_b) ? -quot : quot;
      end
      default: begin
        if (r.op_b == '0) return r.op_a;
        if (overflow) return '0;
        return neg_a ? -rem : rem;
      end
    endcase
  endfunction

  // zero where the divider makes the latency depend on the data
  function automatic int fixed_latency(input md_req_t r);
    case (r.func)
      FN_ADD, FN_SUB:               return 1;
      FN_MUL:                       return 3;
      FN_MULH, FN_MULHSU, FN_MULHU: return 4;
      default:                      return (r.op_b == '0) ? 2 : 0;
    endcase
  endfunction

  ////////////////////////////////////////
  // driver
  ////////////////////////////////////////

  // called a drive delay after an edge with the slice idle
  task automatic issue_op(input md_func_e func, input md_word_t a, input md_word_t b,
                          input logic stray);
    md_req_t r;
    int      cycles;
    int      lat;
    r.func    = func;
    r.op_a    = a;
    r.op_b    = b;
    req       = r;
    req_valid = 1'b1;
    pending.push_back(r);
    n_issued++;
    @(posedge clk);
    #DRIVE_DLY;
    req_valid = 1'b0;
    cycles    = 0;
    while (!result_valid) begin
      // an add strobed while busy must not give a result
      if (stray && cycles == 2) begin
        check_word("busy during stray strobe", {31'b0, busy}, 32'd1);
        req.func  = FN_ADD;
        req.op_b  = ~b;
        req_valid = 1'b1;
      end else begin
        req_valid = 1'b0;
      end
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    req_valid = 1'b0;
    lat       = fixed_latency(r);
    if (lat != 0) begin
      check_word($sformatf("latency of %s", func.name()), cycles, lat);
    end
  endtask

  initial begin : stimulus
    md_word_t a;
    md_word_t b;
    $timeformat(-9, 0, " ns", 0);
    lfsr      = LFSR_SEED;
    n_issued  = 0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    check_word("busy after reset", {31'b0, busy}, '0);
    check_word("result_valid after reset", {31'b0, result_valid}, '0);
    check_word("result after reset", result, '0);

    // random and corner operands, back to back
    for (int f = 0; f < NUM_FUNCS; f++) begin
      for (int i = 0; i < NUM_PER_FUNC; i++) begin
        a = rand_operand();
        b = rand_operand();
        issue_op(md_func_e'(f), a, b, 1'b0);
      end
    end

    // divide by zero and signed overflow
    for (int f = FN_DIV; f <= FN_REMU; f++) begin
      issue_op(md_func_e'(f), rand_word(32), '0, 1'b0);
      issue_op(md_func_e'(f), 32'h8000_0000, '1, 1'b0);
    end

    issue_op(FN_DIV, rand_word(32), rand_word(16) | 32'd1, 1'b1);
    issue_op(FN_REMU, rand_word(32), rand_word(16) | 32'd1, 1'b1);

    repeat (4) @(posedge clk);
    check_word("number of results", n_results, n_issued);
    $display("Test OK");
    $finish;
  end

  ////////////////////////////////////////
  // comparison and watchdog
  ////////////////////////////////////////

  initial begin : compare
    md_req_t  r;
    md_func_e fn;
    n_results = 0;
    forever begin
      @(negedge clk);
      if (result_valid) begin
        if (pending.size() == 0) begin
          stop_run("result_valid_o pulsed with no request outstanding");
        end else begin
          r  = pending.pop_front();
          fn = r.func;
          check_word($sformatf("%s a=%h b=%h", fn.name(), r.op_a, r.op_b), result,
                     ref_result(r));
          n_results++;
        end
      end
    end
  end

  // protocol assertions bound into the DUT
  initial begin : assertion_watch
    wait (dut.u_chk.fail_count != 0);
    stop_run("a protocol assertion on the DUT ports failed");
  end

  initial begin : watchdog
    #(WATCHDOG_CYC * CLK_PERIOD);
    stop_run("timeout: the DUT did not finish all operations in time");
  end

endmodule

// ==== md_unit_top.f ====
src/md_pkg.sv
src/md_issue.sv
src/md_alu.sv
src/md_multdiv_fast.sv
src/md_writeback.sv
src/md_unit_top.sv
dv/md_unit_chk.sv
dv/md_unit_tb.sv

// ==== src/md_alu.sv ====
`timescale 1ns/1ps

module md_alu (
  input  logic                  div_en_i,
  input  md_pkg::md_req_t       req_i,
  input  md_pkg::md_adder_req_t adder_req_i,
  output md_pkg::md_adder_rsp_t adder_rsp_o
);

  import md_pkg::*;

  md_opnd_t opnd_a;
  md_opnd_t opnd_b;
  md_sum_t  sum_ext;
  logic     is_sub;

  assign is_sub = (req_i.func == FN_SUB);

  ////////////////////////////////////////
  // operand selection
  ////////////////////////////////////////

  always_comb begin : operand_mux
    if (div_en_i) begin
      // divider owns the adder
      opnd_a = adder_req_i.opnd_a;
      opnd_b = adder_req_i.opnd_b;
    end else if (is_sub) begin
      // a + ~b + 1
      opnd_a = {req_i.op_a, 1'b1};
      opnd_b = {~req_i.op_b, 1'b1};
    end else begin
      opnd_a = {req_i.op_a, 1'b0};
      opnd_b = {req_i.op_b, 1'b0};
    end
  end

  ////////////////////////////////////////
  // adder
  ////////////////////////////////////////

  // bit 0 only carries the carry-in into bit 1
  assign sum_ext = {1'b0, opnd_a} + {1'b0, opnd_b};

  assign adder_rsp_o.sum_ext = sum_ext;
  assign adder_rsp_o.result  = sum_ext[32:1];
  // zero test on the word, 0 - b is zero only for b zero
  assign adder_rsp_o.is_zero = (sum_ext[32:1] == '0);

endmodule

// ==== src/md_issue.sv ====
`timescale 1ns/1ps

module md_issue (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_valid_i,
  input  md_pkg::md_req_t  req_i,
  input  logic             ready_i,
  output logic             busy_o,
  output md_pkg::md_req_t  held_req_o,
  output md_pkg::md_ctrl_t ctrl_o,
  output logic             use_alu_o,
  output logic             done_o
);

  import md_pkg::*;

  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_EXEC
  } issue_state_e;

  issue_state_e state_q;
  md_ctrl_t     ctrl_q;
  md_ctrl_t     dec_ctrl;
  md_req_t      req_q;
  logic         use_alu_q;
  logic         dec_alu;
  logic         accept;

  assign accept = req_valid_i && (state_q == ISSUE_IDLE);

  // function to kernel controls
  always_comb begin : decode
    dec_ctrl = '0;
    dec_alu  = 1'b0;
    case (req_i.func)
      FN_MUL: begin
        dec_ctrl.mult_en     = 1'b1;
        dec_ctrl.signed_mode = 2'b11;
        dec_ctrl.operator    = MD_OP_MULL;
      end
      FN_MULH: begin
        dec_ctrl.mult_en     = 1'b1;
        dec_ctrl.signed_mode = 2'b11;
        dec_ctrl.operator    = MD_OP_MULH;
      end
      FN_MULHSU: begin
        dec_ctrl.mult_en     = 1'b1;
        dec_ctrl.signed_mode = 2'b01;
        dec_ctrl.operator    = MD_OP_MULH;
      end
      FN_MULHU: begin
        dec_ctrl.mult_en     = 1'b1;
        dec_ctrl.signed_mode = 2'b00;
        dec_ctrl.operator    = MD_OP_MULH;
      end
      FN_DIV, FN_DIVU: begin
        dec_ctrl.div_en      = 1'b1;
        dec_ctrl.signed_mode = (req_i.func == FN_DIV) ? 2'b11 : 2'b00;
        dec_ctrl.operator    = MD_OP_DIV;
      end
      FN_REM, FN_REMU: begin
        dec_ctrl.div_en      = 1'b1;
        dec_ctrl.signed_mode = (req_i.func == FN_REM) ? 2'b11 : 2'b00;
        dec_ctrl.operator    = MD_OP_REM;
      end
      // add, sub and unused codes go to the alu
      default: dec_alu = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : issue_fsm
    if (!rst_ni) begin
      state_q   <= ISSUE_IDLE;
      ctrl_q    <= '0;
      use_alu_q <= 1'b0;
    end else begin
      case (state_q)
        ISSUE_IDLE: begin
          if (accept) begin
            state_q   <= ISSUE_EXEC;
            ctrl_q    <= dec_ctrl;
            use_alu_q <= dec_alu;
          end
        end
        ISSUE_EXEC: begin
          if (done_o) begin
            state_q        <= ISSUE_IDLE;
            ctrl_q.mult_en <= 1'b0;
            ctrl_q.div_en  <= 1'b0;
          end
        end
        default: state_q <= ISSUE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : req_hold
    if (accept) begin
      req_q <= req_i;
    end
  end

  // alu ops finish in their only exec cycle
  assign done_o     = (state_q == ISSUE_EXEC) && (use_alu_q || ready_i);
  assign busy_o     = (state_q == ISSUE_EXEC);
  assign held_req_o = req_q;
  assign ctrl_o     = ctrl_q;
  assign use_alu_o  = use_alu_q;

endmodule

// ==== src/md_multdiv_fast.sv ====
`timescale 1ns/1ps

module md_multdiv_fast (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  md_pkg::md_ctrl_t      ctrl_i,
  input  md_pkg::md_word_t      op_a_i,
  input  md_pkg::md_word_t      op_b_i,
  input  md_pkg::md_adder_rsp_t adder_rsp_i,
  output md_pkg::md_adder_req_t adder_req_o,
  output md_pkg::md_word_t      multdiv_result_o,
  output logic                  ready_o
);

  import md_pkg::*;

  typedef enum logic [1:0] {
    MULT_ALBL,
    MULT_ALBH,
    MULT_AHBL,
    MULT_AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

  mult_state_e mult_state_q, mult_state_d;
  div_state_e  div_state_q, div_state_d;
  logic [4:0]  div_cnt_q, div_cnt_d;

  // mac datapath
  logic signed [34:0] mac_ext;
  md_sum_t     mac_sum;
  md_sum_t     mac_res_q;
  md_sum_t     mac_mult_d;
  md_sum_t     mac_div_d;
  md_sum_t     accum;
  logic [15:0] mult_op_a;
  logic [15:0] mult_op_b;
  logic        sign_a;
  logic        sign_b;
  logic        signed_mult;
  logic        mult_ready;

  // divider datapath
  md_word_t numer_q, numer_d;
  md_word_t denom_q, denom_d;
  md_word_t quot_q, quot_d;
  md_word_t one_shift;
  md_word_t rem_diff;
  md_word_t next_rem;
  md_word_t next_quot;
  md_opnd_t add_a;
  md_opnd_t add_b;
  logic     rem_ge;
  logic     div_sign_a;
  logic     div_sign_b;
  logic     quot_neg;
  logic     rem_neg;

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_regs
    if (!rst_ni) begin
      mult_state_q <= MULT_ALBL;
      div_state_q  <= DIV_IDLE;
      div_cnt_q    <= '0;
    end else begin
      if (ctrl_i.mult_en) begin
        mult_state_q <= mult_state_d;
      end
      if (ctrl_i.div_en) begin
        div_state_q <= div_state_d;
        div_cnt_q   <= div_cnt_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_regs
    if (ctrl_i.mult_en) begin
      mac_res_q <= mac_mult_d;
    end else if (ctrl_i.div_en) begin
      mac_res_q <= mac_div_d;
    end
    if (ctrl_i.div_en) begin
      numer_q <= numer_d;
      denom_q <= denom_d;
      quot_q  <= quot_d;
    end
  end

  assign signed_mult = (ctrl_i.signed_mode != 2'b00);

  // 17x17 signed product plus 34-bit accumulator
  assign mac_ext = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) + $signed(accum);
  assign mac_sum = mac_ext[33:0];

  assign multdiv_result_o = ctrl_i.div_en ? mac_res_q[31:0] : mac_mult_d[31:0];
  assign ready_o          = mult_ready | (div_state_q == DIV_FINISH);

  ////////////////////////////////////////
  // multiplier
  ////////////////////////////////////////

  always_comb begin : mult_fsm
    mult_op_a    = op_a_i[15:0];
    mult_op_b    = op_b_i[15:0];
    sign_a       = 1'b0;
    sign_b       = 1'b0;
    accum        = mac_res_q;
    mac_mult_d   = mac_sum;
    mult_state_d = mult_state_q;
    mult_ready   = 1'b0;
    case (mult_state_q)
      MULT_ALBL: begin
        accum        = '0;
        mult_state_d = MULT_ALBH;
      end
      MULT_ALBH: begin
        // al*bh, shifted by 16 via the accumulator
        mult_op_b = op_b_i[31:16];
        sign_b    = ctrl_i.signed_mode[1] & op_b_i[31];
        accum     = {18'b0, mac_res_q[31:16]};
        if (ctrl_i.operator == MD_OP_MULL) begin
          mac_mult_d = {2'b0, mac_sum[15:0], mac_res_q[15:0]};
        end
        mult_state_d = MULT_AHBL;
      end
      MULT_AHBL: begin
        mult_op_a = op_a_i[31:16];
        sign_a    = ctrl_i.signed_mode[0] & op_a_i[31];
        if (ctrl_i.operator == MD_OP_MULL) begin
          // low word done after this product
          accum        = {18'b0, mac_res_q[31:16]};
          mac_mult_d   = {2'b0, mac_sum[15:0], mac_res_q[15:0]};
          mult_ready   = 1'b1;
          mult_state_d = MULT_ALBL;
        end else begin
          mult_state_d = MULT_AHBH;
        end
      end
      MULT_AHBH: begin
        mult_op_a     = op_a_i[31:16];
        mult_op_b     = op_b_i[31:16];
        sign_a        = ctrl_i.signed_mode[0] & op_a_i[31];
        sign_b        = ctrl_i.signed_mode[1] & op_b_i[31];
        // carry of the middle products, sign extended
        accum[17:0]   = mac_res_q[33:16];
        accum[33:18]  = {16{signed_mult & mac_res_q[33]}};
        mult_ready    = 1'b1;
        mult_state_d  = MULT_ALBL;
      end
      default: mult_state_d = MULT_ALBL;
    endcase
  end

  ////////////////////////////////////////
  // divider
  ////////////////////////////////////////

  assign div_sign_a = op_a_i[31] & ctrl_i.signed_mode[0];
  assign div_sign_b = op_b_i[31] & ctrl_i.signed_mode[1];
  assign quot_neg   = div_sign_a ^ div_sign_b;
  assign rem_neg    = div_sign_a;

  // trial subtraction remainder - divisor
  assign rem_diff  = adder_rsp_i.sum_ext[32:1];
  assign one_shift = {31'b0, 1'b1} << div_cnt_q;
  assign next_rem  = rem_ge ? rem_diff : mac_res_q[31:0];
  assign next_quot = rem_ge ? (quot_q | one_shift) : quot_q;

  // differing sign bits mean the subtraction may have wrapped
  always_comb begin : compare
    if ((mac_res_q[31] ^ denom_q[31]) == 1'b0) begin
      rem_ge = (rem_diff[31] == 1'b0);
    end else begin
      rem_ge = mac_res_q[31];
    end
  end

  always_comb begin : div_fsm
    div_cnt_d   = div_cnt_q - 5'd1;
    mac_div_d   = mac_res_q;
    quot_d      = quot_q;
    numer_d     = numer_q;
    denom_d     = denom_q;
    div_state_d = div_state_q;
    // 0 - b by default
    add_a       = {32'h0, 1'b1};
    add_b       = {~op_b_i, 1'b1};
    case (div_state_q)
      DIV_IDLE: begin
        // preload the divide-by-zero result
        if (ctrl_i.operator == MD_OP_DIV) begin
          mac_div_d = '1;
        end else begin
          mac_div_d = {2'b0, op_a_i};
        end
        div_state_d = adder_rsp_i.is_zero ? DIV_FINISH : DIV_ABS_A;
        div_cnt_d   = 5'd31;
      end
      DIV_ABS_A: begin
        quot_d      = '0;
        numer_d     = div_sign_a ? adder_rsp_i.result : op_a_i;
        add_b       = {~op_a_i, 1'b1};
        div_cnt_d   = 5'd31;
        div_state_d = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        // remainder starts with the top dividend bit
        mac_div_d   = {33'h0, numer_q[31]};
        denom_d     = div_sign_b ? adder_rsp_i.result : op_b_i;
        div_cnt_d   = 5'd31;
        div_state_d = DIV_COMP;
      end
      DIV_COMP: begin
        mac_div_d   = {1'b0, next_rem, numer_q[div_cnt_d]};
        quot_d      = next_quot;
        add_a       = {mac_res_q[31:0], 1'b1};
        add_b       = {~denom_q, 1'b1};
        div_state_d = (div_cnt_q == 5'd1) ? DIV_LAST : DIV_COMP;
      end
      DIV_LAST: begin
        // keep only the value the operator asks for
        if (ctrl_i.operator == MD_OP_DIV) begin
          mac_div_d = {2'b0, next_quot};
        end else begin
          mac_div_d = {2'b0, next_rem};
        end
        add_a       = {mac_res_q[31:0], 1'b1};
        add_b       = {~denom_q, 1'b1};
        div_state_d = DIV_SIGN;
      end
      DIV_SIGN: begin
        if (ctrl_i.operator == MD_OP_DIV) begin
          mac_div_d = quot_neg ? {2'b0, adder_rsp_i.result} : mac_res_q;
        end else begin
          mac_div_d = rem_neg ? {2'b0, adder_rsp_i.result} : mac_res_q;
        end
        add_b       = {~mac_res_q[31:0], 1'b1};
        div_state_d = DIV_FINISH;
      end
      DIV_FINISH: begin
        div_state_d = DIV_IDLE;
      end
      default: div_state_d = DIV_IDLE;
    endcase
  end

  assign adder_req_o.opnd_a = add_a;
  assign adder_req_o.opnd_b = add_b;

endmodule

// ==== src/md_pkg.sv ====
package md_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // operand and result word
  typedef logic [31:0] md_word_t;

  // adder operand, word in the upper bits and carry-in in bit 0
  typedef logic [32:0] md_opnd_t;

  // extended adder output
  typedef logic [33:0] md_sum_t;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    FN_ADD    = 4'd0,
    FN_SUB    = 4'd1,
    FN_MUL    = 4'd2,
    FN_MULH   = 4'd3,
    FN_MULHSU = 4'd4,
    FN_MULHU  = 4'd5,
    FN_DIV    = 4'd6,
    FN_DIVU   = 4'd7,
    FN_REM    = 4'd8,
    FN_REMU   = 4'd9
  } md_func_e;

  // kernel operator
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  typedef struct packed {
    md_func_e func;
    md_word_t op_a;
    md_word_t op_b;
  } md_req_t;

  // signed_mode bit 0 for operand a, bit 1 for operand b
  typedef struct packed {
    logic       mult_en;
    logic       div_en;
    logic [1:0] signed_mode;
    md_op_e     operator;
  } md_ctrl_t;

  typedef struct packed {
    md_opnd_t opnd_a;
    md_opnd_t opnd_b;
  } md_adder_req_t;

  typedef struct packed {
    md_sum_t  sum_ext;
    md_word_t result;
    logic     is_zero;
  } md_adder_rsp_t;

endpackage

// ==== src/md_unit_top.sv ====
`timescale 1ns/1ps

module md_unit_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_valid_i,
  input  md_pkg::md_req_t  req_i,
  output logic             busy_o,
  output logic             result_valid_o,
  output md_pkg::md_word_t result_o
);

  import md_pkg::*;

  md_req_t       held_req;
  md_ctrl_t      ctrl;
  md_adder_req_t adder_req;
  md_adder_rsp_t adder_rsp;
  md_word_t      multdiv_result;
  logic          kernel_ready;
  logic          use_alu;
  logic          done;

  md_issue u_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .ready_i     (kernel_ready),
    .busy_o      (busy_o),
    .held_req_o  (held_req),
    .ctrl_o      (ctrl),
    .use_alu_o   (use_alu),
    .done_o      (done)
  );

  // shared adder for add/sub and the divider
  md_alu u_alu (
    .div_en_i    (ctrl.div_en),
    .req_i       (held_req),
    .adder_req_i (adder_req),
    .adder_rsp_o (adder_rsp)
  );

  md_multdiv_fast u_multdiv (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ctrl_i           (ctrl),
    .op_a_i           (held_req.op_a),
    .op_b_i           (held_req.op_b),
    .adder_rsp_i      (adder_rsp),
    .adder_req_o      (adder_req),
    .multdiv_result_o (multdiv_result),
    .ready_o          (kernel_ready)
  );

  md_writeback u_writeback (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .done_i           (done),
    .use_alu_i        (use_alu),
    .alu_result_i     (adder_rsp.result),
    .multdiv_result_i (multdiv_result),
    .result_valid_o   (result_valid_o),
    .result_o         (result_o)
  );

endmodule

// ==== src/md_writeback.sv ====
`timescale 1ns/1ps

module md_writeback (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             done_i,
  input  logic             use_alu_i,
  input  md_pkg::md_word_t alu_result_i,
  input  md_pkg::md_word_t multdiv_result_i,
  output logic             result_valid_o,
  output md_pkg::md_word_t result_o
);

  import md_pkg::*;

  md_word_t result_sel;
  md_word_t result_q;
  logic     valid_q;

  // alu word for add/sub, kernel word otherwise
  assign result_sel = use_alu_i ? alu_result_i : multdiv_result_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : wb_regs
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      result_q <= '0;
    end else begin
      valid_q <= done_i;
      // held between results
      if (done_i) begin
        result_q <= result_sel;
      end
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;

endmodule
